//--- src/bypass_pkg.sv
//////////////////////////////////////////////////
// Bypass and hazard unit definitions
//////////////////////////////////////////////////

package bypass_pkg;

  //////////////////////////////////////////////////
  // Register file geometry
  //////////////////////////////////////////////////

  // Width of one register index, x0 to x31
  localparam int unsigned RF_ADDR_W = 5;

  // ID reads rs1 on port 0 and rs2 on port 1
  localparam int unsigned NUM_READ_PORTS = 2;

  typedef logic [RF_ADDR_W-1:0] rf_addr_t;

  //////////////////////////////////////////////////
  // Forwarding selects
  //////////////////////////////////////////////////

  // Operand mux select in ID
  // The EX result wins over the WB result when both hold the register
  typedef enum logic [1:0] {
    SEL_REGFILE = 2'b00,
    SEL_FW_EX   = 2'b01,
    SEL_FW_WB   = 2'b10
  } fw_sel_e;

  // Jump target mux select
  // Only a WB result can reach the jump register path, EX is too late
  typedef enum logic {
    SELJ_REGFILE = 1'b0,
    SELJ_FW_WB   = 1'b1
  } jalr_sel_e;

  //////////////////////////////////////////////////
  // Fetch status
  //////////////////////////////////////////////////

  // Result of the MPU check on the instruction fetch
  // Anything but MPU_OK turns the instruction in ID into a bubble
  typedef enum logic [1:0] {
    MPU_OK       = 2'h0,
    MPU_RE_FAULT = 2'h1,
    MPU_WR_FAULT = 2'h2
  } mpu_status_e;

endpackage

//--- src/stage_if.sv
//////////////////////////////////////////////////
// Pipeline stage status bundle
//////////////////////////////////////////////////

`timescale 1ns/1ns

// One instance per stage that can hold a producer (EX or WB)
// None of the fields are qualified with instr_valid here
interface stage_if;

  // Stage holds a real instruction and not a bubble
  logic                 instr_valid;
  // Instruction writes the register file
  logic                 rf_we;
  // Destination register index
  bypass_pkg::rf_addr_t rf_waddr;
  // Load or store in this stage
  logic                 lsu_en;
  // Explicit CSR access
  logic                 csr_en;
  // MRET, which writes mstatus implicitly
  logic                 mret;
  // Wait for interrupt
  logic                 wfi;

  // The top level fills the bundle from its plain ports
  modport source (
    output instr_valid, rf_we, rf_waddr, lsu_en, csr_en, mret, wfi
  );

  // Hazard logic only ever looks
  modport sink (
    input instr_valid, rf_we, rf_waddr, lsu_en, csr_en, mret, wfi
  );

endinterface

//--- src/match_if.sv
//////////////////////////////////////////////////
// Register address match bundle
//////////////////////////////////////////////////

`timescale 1ns/1ns

// Raw address matches between the ID read ports and the producers
// The consumer still has to qualify them with valid and write enable
interface match_if;

  // One bit per ID read port, x0 and disabled ports never match
  logic [bypass_pkg::NUM_READ_PORTS-1:0] ex_match;
  logic [bypass_pkg::NUM_READ_PORTS-1:0] wb_match;

  // Port 0 against each stage for the jump register path
  // The read enable is implied by the JALR and is not looked at
  logic                                  ex_jalr_match;
  logic                                  wb_jalr_match;

  modport source (
    output ex_match, wb_match, ex_jalr_match, wb_jalr_match
  );

  modport sink (
    input ex_match, wb_match, ex_jalr_match, wb_jalr_match
  );

endinterface

//--- src/bypass_select.sv
//////////////////////////////////////////////////
// Operand bypass select
//////////////////////////////////////////////////

`timescale 1ns/1ns

module bypass_select (
  input  logic [bypass_pkg::NUM_READ_PORTS-1:0] rf_re_i,
  input  bypass_pkg::rf_addr_t                  rf_raddr_i [bypass_pkg::NUM_READ_PORTS],
  stage_if.sink                                 ex_i,
  stage_if.sink                                 wb_i,
  match_if.source                               match_o,
  output bypass_pkg::fw_sel_e                   op_a_sel_o,
  output bypass_pkg::fw_sel_e                   op_b_sel_o,
  output bypass_pkg::jalr_sel_e                 jalr_sel_o
);

  logic [bypass_pkg::NUM_READ_PORTS-1:0] ex_match;
  logic [bypass_pkg::NUM_READ_PORTS-1:0] wb_match;
  logic                                  ex_wr;
  logic                                  wb_wr;
  bypass_pkg::fw_sel_e                   port_sel [bypass_pkg::NUM_READ_PORTS];

  // A stage can only forward when it holds a valid instruction that writes
  assign ex_wr = ex_i.instr_valid && ex_i.rf_we;
  assign wb_wr = wb_i.instr_valid && wb_i.rf_we;

  //////////////////////////////////////////////////
  // Address compare
  //////////////////////////////////////////////////

  // x0 reads as zero, so a write to it never has to be bypassed
  for (genvar p = 0; p < bypass_pkg::NUM_READ_PORTS; p++) begin : gen_port_match
    assign ex_match[p] = (ex_i.rf_waddr == rf_raddr_i[p]) && |rf_raddr_i[p] && rf_re_i[p];
    assign wb_match[p] = (wb_i.rf_waddr == rf_raddr_i[p]) && |rf_raddr_i[p] && rf_re_i[p];
  end

  assign match_o.ex_match      = ex_match;
  assign match_o.wb_match      = wb_match;
  // Same compare on rs1 without the read enable
  assign match_o.ex_jalr_match = (ex_i.rf_waddr == rf_raddr_i[0]) && |rf_raddr_i[0];
  assign match_o.wb_jalr_match = (wb_i.rf_waddr == rf_raddr_i[0]) && |rf_raddr_i[0];

  //////////////////////////////////////////////////
  // Forwarding priority
  //////////////////////////////////////////////////

  // EX holds the younger result, so it has to beat WB
  always_comb begin
    for (int p = 0; p < bypass_pkg::NUM_READ_PORTS; p++) begin
      if (ex_wr && ex_match[p]) begin
        port_sel[p] = bypass_pkg::SEL_FW_EX;
      end else if (wb_wr && wb_match[p]) begin
        port_sel[p] = bypass_pkg::SEL_FW_WB;
      end else begin
        port_sel[p] = bypass_pkg::SEL_REGFILE;
      end
    end
  end

  assign op_a_sel_o = port_sel[0];
  assign op_b_sel_o = port_sel[1];

  // Only an ALU result in WB goes to the jump target
  // Loads are stalled elsewhere
  assign jalr_sel_o = (wb_wr && match_o.wb_jalr_match) ? bypass_pkg::SELJ_FW_WB :
                                                         bypass_pkg::SELJ_REGFILE;

endmodule

//--- src/stall_control.sv
//////////////////////////////////////////////////
// Hazard stall control
//////////////////////////////////////////////////

`timescale 1ns/1ns

module stall_control (
  input  logic                    id_valid_i,
  input  logic                    id_jalr_i,
  input  logic                    id_csr_i,
  input  logic                    id_mret_i,
  input  logic                    id_bus_err_i,
  input  logic                    id_trigger_i,
  input  logic                    wb_ready_i,
  input  bypass_pkg::mpu_status_e id_mpu_status_i,
  stage_if.sink                   ex_i,
  stage_if.sink                   wb_i,
  match_if.sink                   match_i,
  output logic                    load_stall_o,
  output logic                    jalr_stall_o,
  output logic                    csr_stall_o,
  output logic                    wfi_stall_o,
  output logic                    deassert_we_o,
  output logic                    id_abort_o
);

  logic ex_wr;
  logic wb_wr;
  logic ex_hz;
  logic wb_hz;
  logic csr_in_id;
  logic csr_write_in_ex_wb;
  logic jalr_in_id;

  //////////////////////////////////////////////////
  // Qualifiers
  //////////////////////////////////////////////////

  // The raw matches know nothing about valid or write enable
  assign ex_wr = ex_i.instr_valid && ex_i.rf_we;
  assign wb_wr = wb_i.instr_valid && wb_i.rf_we;

  // Any read port hitting a live write in that stage
  assign ex_hz = ex_wr && |match_i.ex_match;
  assign wb_hz = wb_wr && |match_i.wb_match;

  assign jalr_in_id = id_valid_i && id_jalr_i;

  // MRET counts as a CSR access because it reads and writes mstatus
  assign csr_in_id = id_valid_i && (id_csr_i || id_mret_i);

  // CSR writes still in flight, explicit ones and those implied by MRET
  assign csr_write_in_ex_wb = (ex_i.instr_valid && (ex_i.csr_en || ex_i.mret)) ||
                              (wb_i.instr_valid && (wb_i.csr_en || wb_i.mret));

  //////////////////////////////////////////////////
  // Stalls
  //////////////////////////////////////////////////

  // A load in EX has no data yet
  // WB data is not final either while the bus has not answered
  assign load_stall_o = (ex_i.lsu_en && ex_hz) || (!wb_ready_i && wb_hz);

  // The jump target only takes WB ALU results
  // Anything in EX and any load in WB has to drain first
  assign jalr_stall_o = jalr_in_id &&
                        ((ex_wr && match_i.ex_jalr_match) ||
                         (wb_wr && wb_i.lsu_en && match_i.wb_jalr_match));

  // Hold a CSR read in ID until older CSR writes have landed
  assign csr_stall_o = csr_in_id && csr_write_in_ex_wb;

  // Keep new work out of EX while a WFI sits there
  assign wfi_stall_o = ex_i.instr_valid && ex_i.wfi;

  // A faulty fetch goes down the pipe as a bubble with no side effects
  // A trigger match is handled the same way
  // Debug mode is entered before execution
  assign deassert_we_o = id_bus_err_i ||
                         (id_mpu_status_i != bypass_pkg::MPU_OK) ||
                         id_trigger_i;

  assign id_abort_o = deassert_we_o;

  // Decode never marks a WFI as a memory access in either stage
  always_comb begin
    assert final (!(ex_i.instr_valid && ex_i.wfi && ex_i.lsu_en) &&
                  !(wb_i.instr_valid && wb_i.wfi && wb_i.lsu_en))
      else $error("WFI flagged as a load or store");
  end

endmodule

//--- src/bypass_unit.sv
//////////////////////////////////////////////////
// Bypass and hazard unit top
//////////////////////////////////////////////////

`timescale 1ns/1ns

module bypass_unit (
  // ID stage
  input  logic [bypass_pkg::NUM_READ_PORTS-1:0] rf_re_id_i,
  input  bypass_pkg::rf_addr_t                  rf_raddr_id_i [bypass_pkg::NUM_READ_PORTS],
  input  logic                                  id_valid_i,
  input  logic                                  id_jalr_i,
  input  logic                                  id_csr_i,
  input  logic                                  id_mret_i,
  input  logic                                  id_bus_err_i,
  input  logic                                  id_trigger_i,
  input  bypass_pkg::mpu_status_e               id_mpu_status_i,
  // EX stage
  input  logic                                  ex_valid_i,
  input  logic                                  ex_rf_we_i,
  input  logic                                  ex_lsu_en_i,
  input  logic                                  ex_csr_en_i,
  input  logic                                  ex_mret_i,
  input  logic                                  ex_wfi_i,
  input  bypass_pkg::rf_addr_t                  ex_rf_waddr_i,
  // WB stage
  input  logic                                  wb_valid_i,
  input  logic                                  wb_rf_we_i,
  input  logic                                  wb_lsu_en_i,
  input  logic                                  wb_csr_en_i,
  input  logic                                  wb_mret_i,
  input  logic                                  wb_wfi_i,
  input  bypass_pkg::rf_addr_t                  wb_rf_waddr_i,
  input  logic                                  wb_ready_i,
  // Forwarding selects
  output bypass_pkg::fw_sel_e                   op_a_fw_sel_o,
  output bypass_pkg::fw_sel_e                   op_b_fw_sel_o,
  output bypass_pkg::jalr_sel_e                 jalr_fw_sel_o,
  // Stalls and kill
  output logic                                  load_stall_o,
  output logic                                  jalr_stall_o,
  output logic                                  csr_stall_o,
  output logic                                  wfi_stall_o,
  output logic                                  deassert_we_o,
  output logic                                  id_abort_o
);

  stage_if ex_stage ();
  stage_if wb_stage ();
  match_if rf_match ();

  // Producer side of EX
  assign ex_stage.instr_valid = ex_valid_i;
  assign ex_stage.rf_we       = ex_rf_we_i;
  assign ex_stage.rf_waddr    = ex_rf_waddr_i;
  assign ex_stage.lsu_en      = ex_lsu_en_i;
  assign ex_stage.csr_en      = ex_csr_en_i;
  assign ex_stage.mret        = ex_mret_i;
  assign ex_stage.wfi         = ex_wfi_i;

  // Producer side of WB
  assign wb_stage.instr_valid = wb_valid_i;
  assign wb_stage.rf_we       = wb_rf_we_i;
  assign wb_stage.rf_waddr    = wb_rf_waddr_i;
  assign wb_stage.lsu_en      = wb_lsu_en_i;
  assign wb_stage.csr_en      = wb_csr_en_i;
  assign wb_stage.mret        = wb_mret_i;
  assign wb_stage.wfi         = wb_wfi_i;

  // Address compare and mux selects
  bypass_select u_bypass_select (
    .rf_re_i    (rf_re_id_i),
    .rf_raddr_i (rf_raddr_id_i),
    .ex_i       (ex_stage),
    .wb_i       (wb_stage),
    .match_o    (rf_match),
    .op_a_sel_o (op_a_fw_sel_o),
    .op_b_sel_o (op_b_fw_sel_o),
    .jalr_sel_o (jalr_fw_sel_o)
  );

  // Hazard stalls built on the raw matches
  stall_control u_stall_control (
    .id_valid_i      (id_valid_i),
    .id_jalr_i       (id_jalr_i),
    .id_csr_i        (id_csr_i),
    .id_mret_i       (id_mret_i),
    .id_bus_err_i    (id_bus_err_i),
    .id_trigger_i    (id_trigger_i),
    .wb_ready_i      (wb_ready_i),
    .id_mpu_status_i (id_mpu_status_i),
    .ex_i            (ex_stage),
    .wb_i            (wb_stage),
    .match_i         (rf_match),
    .load_stall_o    (load_stall_o),
    .jalr_stall_o    (jalr_stall_o),
    .csr_stall_o     (csr_stall_o),
    .wfi_stall_o     (wfi_stall_o),
    .deassert_we_o   (deassert_we_o),
    .id_abort_o      (id_abort_o)
  );

endmodule

//--- bench/tb_checks.svh
//////////////////////////////////////////////////
// Testbench compare tasks
//////////////////////////////////////////////////

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

  //////////////////////////////////////////////////
  // Failure exit
  //////////////////////////////////////////////////

  // Ends the run right at the first failure
  task automatic stop_with_failure();
    $display("Test failures found");
    $fatal(1);
  endtask

  //////////////////////////////////////////////////
  // Compares, one per result type
  //////////////////////////////////////////////////

  // Operand forwarding select
  task automatic fw_sel_equal(input string               name,
                              input bypass_pkg::fw_sel_e got,
                              input bypass_pkg::fw_sel_e exp);
    if (got !== exp) begin
      $display("Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
      stop_with_failure();
    end
  endtask

  // Jump register forwarding select
  task automatic jalr_sel_equal(input string                 name,
                                input bypass_pkg::jalr_sel_e got,
                                input bypass_pkg::jalr_sel_e exp);
    if (got !== exp) begin
      $display("Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
      stop_with_failure();
    end
  endtask

  // Single stall or kill flag
  // The !== also catches an X on the output
  task automatic flag_equal(input string name,
                            input logic  got,
                            input logic  exp);
    if (got !== exp) begin
      $display("Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
      stop_with_failure();
    end
  endtask

`endif

//--- bench/tb_bypass_unit.sv
//////////////////////////////////////////////////
// Bypass and hazard unit testbench
//////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_bypass_unit;

  localparam int unsigned LFSR_SEED = 87617;

  logic clk;
  logic rst_i;
  logic [15:0] lfsr;

  // DUT inputs
  // They carry the port names so that the instance can use .*
  logic [bypass_pkg::NUM_READ_PORTS-1:0] rf_re_id_i;
  bypass_pkg::rf_addr_t    rf_raddr_id_i [bypass_pkg::NUM_READ_PORTS];
  logic                    id_valid_i, id_jalr_i, id_csr_i, id_mret_i;
  logic                    id_bus_err_i, id_trigger_i;
  bypass_pkg::mpu_status_e id_mpu_status_i;
  logic                    ex_valid_i, ex_rf_we_i, ex_lsu_en_i;
  logic                    ex_csr_en_i, ex_mret_i, ex_wfi_i;
  bypass_pkg::rf_addr_t    ex_rf_waddr_i;
  logic                    wb_valid_i, wb_rf_we_i, wb_lsu_en_i;
  logic                    wb_csr_en_i, wb_mret_i, wb_wfi_i;
  bypass_pkg::rf_addr_t    wb_rf_waddr_i;
  logic                    wb_ready_i;

  // DUT outputs
  bypass_pkg::fw_sel_e   op_a_fw_sel_o, op_b_fw_sel_o;
  bypass_pkg::jalr_sel_e jalr_fw_sel_o;
  logic                  load_stall_o, jalr_stall_o, csr_stall_o, wfi_stall_o;
  logic                  deassert_we_o, id_abort_o;

  bypass_unit dut (.*);

  `include "tb_checks.svh"

  // Rising edges fall on 2, 6, 10 and so on
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    rst_i = 1'b1;
    repeat (3) @(posedge clk);
    rst_i <= 1'b0;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // Polls on odd times, so it never meets a clock edge in the same step
  // Returns 1 ns after the next rising edge
  task automatic next_cycle();
    logic seen_low;
    int   n;
    seen_low = 1'b0;
    for (n = 0; n < 4; n++) begin
      #2;
      if (!clk) begin
        seen_low = 1'b1;
      end else if (seen_low) begin
        break;
      end
    end
    if (n == 4) begin
      $display("Clock did not reach its next rising edge");
      stop_with_failure();
    end
  endtask

  task automatic wait_reset_release();
    int n;
    for (n = 0; n < 8; n++) begin
      if (!rst_i) break;
      next_cycle();
    end
    if (rst_i) begin
      $display("Reset was not released in time");
      stop_with_failure();
    end
  endtask

  // Taps 16, 14, 13 and 11
  // One shift per bit handed out
  function automatic logic lfsr_step();
    logic fb;
    fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  // Addresses stay within x0 to x3 so that matches and x0 both come up often
  function automatic bypass_pkg::rf_addr_t random_addr();
    bypass_pkg::rf_addr_t a;
    a      = '0;
    a[1:0] = {lfsr_step(), lfsr_step()};
    return a;
  endfunction

  // EX beats WB
  // x0 and a disabled read port never forward
  function automatic bypass_pkg::fw_sel_e expected_fw_sel(input int p);
    logic usable;
    usable = rf_re_id_i[p] && (rf_raddr_id_i[p] != '0);
    if (usable && ex_valid_i && ex_rf_we_i && (rf_raddr_id_i[p] == ex_rf_waddr_i)) begin
      return bypass_pkg::SEL_FW_EX;
    end
    if (usable && wb_valid_i && wb_rf_we_i && (rf_raddr_id_i[p] == wb_rf_waddr_i)) begin
      return bypass_pkg::SEL_FW_WB;
    end
    return bypass_pkg::SEL_REGFILE;
  endfunction

  // Empty pipeline with the bus ready
  task automatic idle_inputs();
    rf_re_id_i       = '0;
    rf_raddr_id_i[0] = '0;
    rf_raddr_id_i[1] = '0;
    id_valid_i       = 1'b0;
    id_jalr_i        = 1'b0;
    id_csr_i         = 1'b0;
    id_mret_i        = 1'b0;
    id_bus_err_i     = 1'b0;
    id_trigger_i     = 1'b0;
    id_mpu_status_i  = bypass_pkg::MPU_OK;
    ex_valid_i       = 1'b0;
    ex_rf_we_i       = 1'b0;
    ex_lsu_en_i      = 1'b0;
    ex_csr_en_i      = 1'b0;
    ex_mret_i        = 1'b0;
    ex_wfi_i         = 1'b0;
    ex_rf_waddr_i    = '0;
    wb_valid_i       = 1'b0;
    wb_rf_we_i       = 1'b0;
    wb_lsu_en_i      = 1'b0;
    wb_csr_en_i      = 1'b0;
    wb_mret_i        = 1'b0;
    wb_wfi_i         = 1'b0;
    wb_rf_waddr_i    = '0;
    wb_ready_i       = 1'b1;
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  task automatic forwarding_priority();
    for (int c = 0; c < 200; c++) begin
      idle_inputs();
      rf_re_id_i       = {lfsr_step(), lfsr_step()};
      rf_raddr_id_i[0] = random_addr();
      rf_raddr_id_i[1] = random_addr();
      ex_valid_i       = lfsr_step();
      ex_rf_we_i       = lfsr_step();
      ex_rf_waddr_i    = random_addr();
      wb_valid_i       = lfsr_step();
      wb_rf_we_i       = lfsr_step();
      wb_rf_waddr_i    = random_addr();
      next_cycle();
      fw_sel_equal("op_a_fw_sel_o", op_a_fw_sel_o, expected_fw_sel(0));
      fw_sel_equal("op_b_fw_sel_o", op_b_fw_sel_o, expected_fw_sel(1));
    end
  endtask

  task automatic load_use_stall();
    // Load in EX feeding rs2
    idle_inputs();
    rf_re_id_i       = 2'b10;
    rf_raddr_id_i[1] = 5'd5;
    ex_valid_i       = 1'b1;
    ex_rf_we_i       = 1'b1;
    ex_lsu_en_i      = 1'b1;
    ex_rf_waddr_i    = 5'd5;
    next_cycle();
    flag_equal("load_stall_o", load_stall_o, 1'b1);
    // WB write on rs1 while the bus has not answered
    idle_inputs();
    rf_re_id_i       = 2'b01;
    rf_raddr_id_i[0] = 5'd7;
    wb_valid_i       = 1'b1;
    wb_rf_we_i       = 1'b1;
    wb_rf_waddr_i    = 5'd7;
    wb_ready_i       = 1'b0;
    next_cycle();
    flag_equal("load_stall_o", load_stall_o, 1'b1);
    // Bus ready and an ALU result in EX on the same register simply forward
    wb_ready_i    = 1'b1;
    ex_valid_i    = 1'b1;
    ex_rf_we_i    = 1'b1;
    ex_rf_waddr_i = 5'd7;
    next_cycle();
    flag_equal("load_stall_o", load_stall_o, 1'b0);
  endtask

  task automatic jalr_hazards();
    // Read enables stay low
    // The jalr compare must not need them
    idle_inputs();
    id_valid_i       = 1'b1;
    id_jalr_i        = 1'b1;
    rf_raddr_id_i[0] = 5'd9;
    ex_valid_i       = 1'b1;
    ex_rf_we_i       = 1'b1;
    ex_rf_waddr_i    = 5'd9;
    next_cycle();
    flag_equal("jalr_stall_o", jalr_stall_o, 1'b1);
    jalr_sel_equal("jalr_fw_sel_o", jalr_fw_sel_o, bypass_pkg::SELJ_REGFILE);
    // Load result in WB
    ex_valid_i    = 1'b0;
    wb_valid_i    = 1'b1;
    wb_rf_we_i    = 1'b1;
    wb_lsu_en_i   = 1'b1;
    wb_rf_waddr_i = 5'd9;
    next_cycle();
    flag_equal("jalr_stall_o", jalr_stall_o, 1'b1);
    // ALU result in WB goes straight to the jump target
    wb_lsu_en_i = 1'b0;
    next_cycle();
    flag_equal("jalr_stall_o", jalr_stall_o, 1'b0);
    jalr_sel_equal("jalr_fw_sel_o", jalr_fw_sel_o, bypass_pkg::SELJ_FW_WB);
    // No jump in ID at all
    id_jalr_i  = 1'b0;
    ex_valid_i = 1'b1;
    next_cycle();
    flag_equal("jalr_stall_o", jalr_stall_o, 1'b0);
  endtask

  task automatic csr_hazards();
    // Bit 0 picks the ID kind, bit 1 the producer kind, bit 2 the stage
    for (int i = 0; i < 8; i++) begin
      idle_inputs();
      id_valid_i  = 1'b1;
      id_csr_i    = !i[0];
      id_mret_i   = i[0];
      ex_valid_i  = !i[2];
      ex_csr_en_i = !i[2] && !i[1];
      ex_mret_i   = !i[2] && i[1];
      wb_valid_i  = i[2];
      wb_csr_en_i = i[2] && !i[1];
      wb_mret_i   = i[2] && i[1];
      next_cycle();
      flag_equal("csr_stall_o", csr_stall_o, 1'b1);
    end
    // Bubbles carrying stale CSR flags
    idle_inputs();
    id_valid_i  = 1'b1;
    id_csr_i    = 1'b1;
    ex_csr_en_i = 1'b1;
    wb_mret_i   = 1'b1;
    next_cycle();
    flag_equal("csr_stall_o", csr_stall_o, 1'b0);
  endtask

  task automatic wfi_and_fetch_faults();
    idle_inputs();
    ex_valid_i = 1'b1;
    ex_wfi_i   = 1'b1;
    next_cycle();
    flag_equal("wfi_stall_o", wfi_stall_o, 1'b1);
    ex_valid_i = 1'b0;
    next_cycle();
    flag_equal("wfi_stall_o", wfi_stall_o, 1'b0);
    // Case 0 is a clean fetch
    // Every other case has exactly one cause
    for (int k = 0; k < 5; k++) begin
      idle_inputs();
      id_valid_i      = 1'b1;
      id_bus_err_i    = (k == 1);
      id_trigger_i    = (k == 2);
      id_mpu_status_i = (k == 3) ? bypass_pkg::MPU_RE_FAULT :
                        (k == 4) ? bypass_pkg::MPU_WR_FAULT : bypass_pkg::MPU_OK;
      next_cycle();
      flag_equal("deassert_we_o", deassert_we_o, k != 0);
      flag_equal("id_abort_o", id_abort_o, k != 0);
    end
  endtask

  //////////////////////////////////////////////////
  // Sequence
  //////////////////////////////////////////////////

  initial begin
    // The seed is wider than the register
    // Its low 16 bits are loaded
    lfsr = LFSR_SEED[15:0];
    idle_inputs();
    #1;
    wait_reset_release();
    forwarding_priority();
    load_use_stall();
    jalr_hazards();
    csr_hazards();
    wfi_and_fetch_faults();
    $display("All tests passed!");
    $finish;
  end

endmodule

//--- sources.f
+incdir+bench
src/bypass_pkg.sv
src/stage_if.sv
src/match_if.sv
src/bypass_select.sv
src/stall_control.sv
src/bypass_unit.sv
bench/tb_bypass_unit.sv

//--- Makefile
# Verilator simulation of the bypass and hazard unit
# A failing check ends in $fatal, so the model exits with a failing status

VERILATOR ?= verilator
TOP       ?= tb_bypass_unit
FLAGS     ?= --assert -j 0
BUILD_DIR ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing $(FLAGS) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f sources.f
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
